//--- design/fe_cmd_pkg.sv
// Front-end command format
//   opcode, redirect subopcode and mispredict reason codes
//   privilege and branch metadata widths
//   operand word, decoded as redirect or as attaboy operands
`default_nettype none

package fe_cmd_pkg;

  localparam int opcode_width   = 3;
  localparam int subop_width    = 2;
  localparam int reason_width   = 2;
  localparam int priv_width     = 2;
  localparam int metadata_width = 8;

  // Opcodes toward the front end
  localparam logic [opcode_width-1:0] fe_op_state_reset  = 3'd0;
  localparam logic [opcode_width-1:0] fe_op_pc_redirect  = 3'd1;
  localparam logic [opcode_width-1:0] fe_op_icache_fence = 3'd2;
  localparam logic [opcode_width-1:0] fe_op_wait         = 3'd3;
  localparam logic [opcode_width-1:0] fe_op_attaboy      = 3'd4;

  // Redirect subopcodes
  localparam logic [subop_width-1:0] fe_subop_eret              = 2'd0;
  localparam logic [subop_width-1:0] fe_subop_trap              = 2'd1;
  localparam logic [subop_width-1:0] fe_subop_branch_mispredict = 2'd2;

  // Why a mispredict redirect was sent
  localparam logic [reason_width-1:0] fe_reason_not_a_branch      = 2'd0;
  localparam logic [reason_width-1:0] fe_reason_pred_taken_wrong  = 2'd1;
  localparam logic [reason_width-1:0] fe_reason_pred_ntaken_wrong = 2'd2;

  localparam int redirect_pad_width =
    16 - subop_width - priv_width - reason_width - metadata_width;
  localparam int attaboy_pad_width = 16 - 1 - metadata_width;

  // One 16-bit operand word with two decodings
  typedef union packed {
    struct packed {
      logic [redirect_pad_width-1:0] pad;
      logic [subop_width-1:0]        subop;
      logic [priv_width-1:0]         priv;
      logic [reason_width-1:0]       reason;
      logic [metadata_width-1:0]     metadata;
    } redirect;
    struct packed {
      logic [attaboy_pad_width-1:0]  pad;
      logic                          taken;
      logic [metadata_width-1:0]     metadata;
    } attaboy;
  } fe_operands_u;

endpackage

`default_nettype wire

//--- design/be_dir_pkg.sv
// Back-end director definitions
//   state codes of the boot and run machine
//   default address width and command queue depth
`default_nettype none

package be_dir_pkg;

  localparam int state_width = 2;

  localparam logic [state_width-1:0] state_freeze = 2'd0;
  localparam logic [state_width-1:0] state_run    = 2'd1;
  localparam logic [state_width-1:0] state_fence  = 2'd2;
  localparam logic [state_width-1:0] state_wait   = 2'd3;

  // Sv39 virtual addresses
  localparam int default_vaddr_width = 39;
  localparam int default_queue_els   = 4;

endpackage

`default_nettype wire

//--- design/npc_tracker.sv
// Next-PC tracker
//   next-PC register written by commit or branch resolution
//   expected PC, issue mismatch and poison
//   branch and taken pending flags
`timescale 1ns/10ps
`default_nettype none

module npc_tracker
  #(parameter int vaddr_width_p = be_dir_pkg::default_vaddr_width)
  (input  wire logic                     clk_i
  ,input  wire logic                     reset_i
  ,input  wire logic                     commit_npc_w_v_i
  ,input  wire logic [vaddr_width_p-1:0] commit_npc_i
  ,input  wire logic                     br_v_i
  ,input  wire logic [vaddr_width_p-1:0] br_npc_i
  ,input  wire logic                     br_branch_i
  ,input  wire logic                     br_btaken_i
  ,input  wire logic                     isd_v_i
  ,input  wire logic [vaddr_width_p-1:0] isd_pc_i
  ,output logic      [vaddr_width_p-1:0] expected_npc_o
  ,output logic      [vaddr_width_p-1:0] npc_r_o
  ,output logic                          mismatch_o
  ,output logic                          poison_isd_o
  ,output logic                          last_branch_o
  ,output logic                          last_btaken_o
  );

  logic                     npc_w_v;
  logic [vaddr_width_p-1:0] npc_n;
  logic                     branch_pending_r;
  logic                     btaken_pending_r;
  logic                     branch_set;
  logic                     btaken_set;

  // Commit has priority over the branch unit
  assign npc_w_v = commit_npc_w_v_i | br_v_i;
  assign npc_n   = commit_npc_w_v_i ? commit_npc_i : br_npc_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      npc_r_o <= '0;
    else if (npc_w_v)
      npc_r_o <= npc_n;
  end

  // Bypass the value being written this cycle
  assign expected_npc_o = npc_w_v ? npc_n : npc_r_o;

  assign mismatch_o   = isd_v_i & (isd_pc_i != expected_npc_o);
  assign poison_isd_o = commit_npc_w_v_i | mismatch_o;

  assign branch_set = br_v_i & br_branch_i;
  assign btaken_set = br_v_i & br_btaken_i;

  // Cleared by the next issue even on a new branch
  always_ff @(posedge clk_i)
  begin
    if (reset_i | isd_v_i)
    begin
      branch_pending_r <= 1'b0;
      btaken_pending_r <= 1'b0;
    end
    else
    begin
      branch_pending_r <= branch_pending_r | branch_set;
      btaken_pending_r <= btaken_pending_r | btaken_set;
    end
  end

  assign last_branch_o = branch_pending_r | branch_set;
  assign last_btaken_o = btaken_pending_r | btaken_set;

endmodule

`default_nettype wire

//--- design/director_fsm.sv
// Boot and run state machine
//   freeze, wait, run and fence states
//   issue suppression and unfreeze pulse
`timescale 1ns/10ps
`default_nettype none

module director_fsm
  (input  wire logic                              clk_i
  ,input  wire logic                              reset_i
  ,input  wire logic                              freeze_i
  ,input  wire logic                              commit_wfi_i
  ,input  wire logic                              cmd_enq_v_i
  ,input  wire logic [fe_cmd_pkg::opcode_width-1:0] cmd_enq_opcode_i
  ,input  wire logic                              queue_empty_n_i
  ,output logic                                   suppress_iss_o
  ,output logic                                   unfreeze_o
  ,output logic                                   is_wait_o
  );

  logic [be_dir_pkg::state_width-1:0] state_r;
  logic [be_dir_pkg::state_width-1:0] state_n;
  logic                               freeze_li;
  logic                               nonattaboy_v;

  assign freeze_li    = freeze_i | reset_i;
  assign nonattaboy_v = cmd_enq_v_i & (cmd_enq_opcode_i != fe_cmd_pkg::fe_op_attaboy);

  always_comb
  begin
    case (state_r)
      be_dir_pkg::state_wait:
        state_n = nonattaboy_v ? be_dir_pkg::state_fence : be_dir_pkg::state_wait;
      be_dir_pkg::state_run:
        if (commit_wfi_i)
          state_n = be_dir_pkg::state_wait;
        else if (nonattaboy_v)
          state_n = be_dir_pkg::state_fence;
        else
          state_n = be_dir_pkg::state_run;
      // Wait for the front end to drain its commands
      be_dir_pkg::state_fence:
        state_n = queue_empty_n_i ? be_dir_pkg::state_run : be_dir_pkg::state_fence;
      default:
        state_n = freeze_li ? be_dir_pkg::state_freeze : be_dir_pkg::state_wait;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= be_dir_pkg::state_freeze;
    else
      state_r <= state_n;
  end

  assign suppress_iss_o = (state_r != be_dir_pkg::state_run);
  assign unfreeze_o     = (state_r == be_dir_pkg::state_freeze) & ~freeze_li;
  assign is_wait_o      = (state_r == be_dir_pkg::state_wait);

endmodule

`default_nettype wire

//--- design/fe_cmd_encoder.sv
// Front-end command encoder
//   priority selection of one command per cycle
//   state reset, wait, fence, eret, trap, mispredict and attaboy
`timescale 1ns/10ps
`default_nettype none

module fe_cmd_encoder
  #(parameter int vaddr_width_p = be_dir_pkg::default_vaddr_width)
  (input  wire logic                                  commit_unfreeze_i
  ,input  wire logic                                  commit_wfi_i
  ,input  wire logic                                  commit_fencei_i
  ,input  wire logic                                  commit_eret_i
  ,input  wire logic                                  commit_exception_i
  ,input  wire logic                                  commit_interrupt_i
  ,input  wire logic [vaddr_width_p-1:0]              commit_npc_i
  ,input  wire logic [fe_cmd_pkg::priv_width-1:0]     commit_priv_i
  ,input  wire logic [vaddr_width_p-1:0]              npc_r_i
  ,input  wire logic [vaddr_width_p-1:0]              expected_npc_i
  ,input  wire logic                                  mismatch_i
  ,input  wire logic                                  last_branch_i
  ,input  wire logic                                  last_btaken_i
  ,input  wire logic                                  isd_v_i
  ,input  wire logic [fe_cmd_pkg::metadata_width-1:0] isd_metadata_i
  ,input  wire logic                                  is_wait_i
  ,input  wire logic                                  irq_waiting_i
  ,input  wire logic                                  queue_ready_i
  ,output logic                                       cmd_v_o
  ,output logic      [fe_cmd_pkg::opcode_width-1:0]   cmd_opcode_o
  ,output logic      [vaddr_width_p-1:0]              cmd_vaddr_o
  ,output fe_cmd_pkg::fe_operands_u                   cmd_operands_o
  );

  logic cmd_found;
  logic trap_v;

  assign trap_v = commit_exception_i | commit_interrupt_i | (is_wait_i & irq_waiting_i);

  always_comb
  begin
    cmd_found      = 1'b1;
    cmd_opcode_o   = fe_cmd_pkg::fe_op_state_reset;
    cmd_vaddr_o    = commit_npc_i;
    cmd_operands_o = '0;

    if (commit_unfreeze_i)
    begin
      cmd_vaddr_o                  = npc_r_i;
      cmd_operands_o.redirect.priv = commit_priv_i;
    end
    else if (commit_wfi_i)
      cmd_opcode_o = fe_cmd_pkg::fe_op_wait;
    else if (commit_fencei_i)
      cmd_opcode_o = fe_cmd_pkg::fe_op_icache_fence;
    else if (commit_eret_i)
    begin
      cmd_opcode_o                  = fe_cmd_pkg::fe_op_pc_redirect;
      cmd_operands_o.redirect.subop = fe_cmd_pkg::fe_subop_eret;
      cmd_operands_o.redirect.priv  = commit_priv_i;
    end
    else if (trap_v)
    begin
      cmd_opcode_o                  = fe_cmd_pkg::fe_op_pc_redirect;
      cmd_operands_o.redirect.subop = fe_cmd_pkg::fe_subop_trap;
      cmd_operands_o.redirect.priv  = commit_priv_i;
    end
    else if (mismatch_i)
    begin
      cmd_opcode_o                     = fe_cmd_pkg::fe_op_pc_redirect;
      cmd_vaddr_o                      = expected_npc_i;
      cmd_operands_o.redirect.subop    = fe_cmd_pkg::fe_subop_branch_mispredict;
      cmd_operands_o.redirect.metadata = isd_metadata_i;
      if (!last_branch_i)
        cmd_operands_o.redirect.reason = fe_cmd_pkg::fe_reason_not_a_branch;
      else if (last_btaken_i)
        cmd_operands_o.redirect.reason = fe_cmd_pkg::fe_reason_pred_taken_wrong;
      else
        cmd_operands_o.redirect.reason = fe_cmd_pkg::fe_reason_pred_ntaken_wrong;
    end
    // Correct prediction feedback
    else if (isd_v_i & last_branch_i)
    begin
      cmd_opcode_o                    = fe_cmd_pkg::fe_op_attaboy;
      cmd_vaddr_o                     = expected_npc_i;
      cmd_operands_o.attaboy.taken    = last_btaken_i;
      cmd_operands_o.attaboy.metadata = isd_metadata_i;
    end
    else
      cmd_found = 1'b0;
  end

  // Dropped when the queue is full
  assign cmd_v_o = cmd_found & queue_ready_i;

endmodule

`default_nettype wire

//--- design/fe_cmd_queue.sv
// Front-end command queue
//   circular FIFO with read and write pointers and a count
//   valid/yumi output, next-empty and registered empty and full flags
`timescale 1ns/10ps
`default_nettype none

module fe_cmd_queue
  #(parameter int vaddr_width_p = be_dir_pkg::default_vaddr_width
  ,parameter int queue_els_p   = be_dir_pkg::default_queue_els)
  (input  wire logic                                clk_i
  ,input  wire logic                                reset_i
  ,input  wire logic                                enq_v_i
  ,input  wire logic [fe_cmd_pkg::opcode_width-1:0] enq_opcode_i
  ,input  wire logic [vaddr_width_p-1:0]            enq_vaddr_i
  ,input  wire fe_cmd_pkg::fe_operands_u            enq_operands_i
  ,input  wire logic                                fe_cmd_yumi_i
  ,output logic                                     ready_o
  ,output logic                                     fe_cmd_v_o
  ,output logic      [fe_cmd_pkg::opcode_width-1:0] fe_cmd_opcode_o
  ,output logic      [vaddr_width_p-1:0]            fe_cmd_vaddr_o
  ,output fe_cmd_pkg::fe_operands_u                 fe_cmd_operands_o
  ,output logic                                     empty_n_o
  ,output logic                                     empty_r_o
  ,output logic                                     full_r_o
  );

  localparam int ptr_width_lp = (queue_els_p > 1) ? $clog2(queue_els_p) : 1;
  localparam int cnt_width_lp = $clog2(queue_els_p + 1);
  localparam logic [ptr_width_lp-1:0] last_ptr_lp = ptr_width_lp'(queue_els_p - 1);

  logic [fe_cmd_pkg::opcode_width-1:0] opcode_mem [queue_els_p];
  logic [vaddr_width_p-1:0]            vaddr_mem [queue_els_p];
  fe_cmd_pkg::fe_operands_u            operands_mem [queue_els_p];

  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic [cnt_width_lp-1:0] count_n;
  logic                    enq;
  logic                    deq;

  assign ready_o    = ~full_r_o;
  assign fe_cmd_v_o = ~empty_r_o;
  assign enq        = enq_v_i & ready_o;
  assign deq        = fe_cmd_yumi_i & fe_cmd_v_o;

  assign count_n   = count_r + cnt_width_lp'(enq) - cnt_width_lp'(deq);
  assign empty_n_o = (count_n == '0);

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      opcode_mem[wptr_r]   <= enq_opcode_i;
      vaddr_mem[wptr_r]    <= enq_vaddr_i;
      operands_mem[wptr_r] <= enq_operands_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r    <= '0;
      rptr_r    <= '0;
      count_r   <= '0;
      empty_r_o <= 1'b1;
      full_r_o  <= 1'b0;
    end
    else
    begin
      if (enq)
        wptr_r <= (wptr_r == last_ptr_lp) ? '0 : wptr_r + 1'b1;
      if (deq)
        rptr_r <= (rptr_r == last_ptr_lp) ? '0 : rptr_r + 1'b1;
      count_r   <= count_n;
      empty_r_o <= empty_n_o;
      full_r_o  <= (count_n == cnt_width_lp'(queue_els_p));
    end
  end

  // Head of queue
  assign fe_cmd_opcode_o   = opcode_mem[rptr_r];
  assign fe_cmd_vaddr_o    = vaddr_mem[rptr_r];
  assign fe_cmd_operands_o = operands_mem[rptr_r];

endmodule

`default_nettype wire

//--- design/be_director.sv
// Back-end director top level
//   next-PC tracker, boot and run FSM
//   command encoder and front-end command queue
`timescale 1ns/10ps
`default_nettype none

module be_director
  #(parameter int vaddr_width_p = be_dir_pkg::default_vaddr_width
  ,parameter int queue_els_p   = be_dir_pkg::default_queue_els)
  (input  wire logic                                  clk_i
  ,input  wire logic                                  reset_i
  ,input  wire logic                                  commit_npc_w_v_i
  ,input  wire logic [vaddr_width_p-1:0]              commit_npc_i
  ,input  wire logic                                  commit_unfreeze_i
  ,input  wire logic                                  commit_wfi_i
  ,input  wire logic                                  commit_fencei_i
  ,input  wire logic                                  commit_eret_i
  ,input  wire logic                                  commit_exception_i
  ,input  wire logic                                  commit_interrupt_i
  ,input  wire logic [fe_cmd_pkg::priv_width-1:0]     commit_priv_i
  ,input  wire logic                                  br_v_i
  ,input  wire logic [vaddr_width_p-1:0]              br_npc_i
  ,input  wire logic                                  br_branch_i
  ,input  wire logic                                  br_btaken_i
  ,input  wire logic                                  isd_v_i
  ,input  wire logic [vaddr_width_p-1:0]              isd_pc_i
  ,input  wire logic [fe_cmd_pkg::metadata_width-1:0] isd_metadata_i
  ,input  wire logic                                  freeze_i
  ,input  wire logic                                  irq_waiting_i
  ,output logic      [vaddr_width_p-1:0]              expected_npc_o
  ,output logic                                       poison_isd_o
  ,output logic                                       suppress_iss_o
  ,output logic                                       unfreeze_o
  ,output logic                                       cmd_empty_o
  ,output logic                                       cmd_full_o
  ,output logic      [fe_cmd_pkg::opcode_width-1:0]   fe_cmd_opcode_o
  ,output logic      [vaddr_width_p-1:0]              fe_cmd_vaddr_o
  ,output fe_cmd_pkg::fe_operands_u                   fe_cmd_operands_o
  ,output logic                                       fe_cmd_v_o
  ,input  wire logic                                  fe_cmd_yumi_i
  );

  logic [vaddr_width_p-1:0]            npc_r;
  logic                                mismatch;
  logic                                last_branch;
  logic                                last_btaken;
  logic                                is_wait;
  logic                                queue_ready;
  logic                                empty_n;
  logic                                cmd_v;
  logic [fe_cmd_pkg::opcode_width-1:0] cmd_opcode;
  logic [vaddr_width_p-1:0]            cmd_vaddr;
  fe_cmd_pkg::fe_operands_u            cmd_operands;

  npc_tracker #(.vaddr_width_p(vaddr_width_p)) i_npc_tracker
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.commit_npc_w_v_i(commit_npc_w_v_i), .commit_npc_i(commit_npc_i)
    ,.br_v_i(br_v_i), .br_npc_i(br_npc_i)
    ,.br_branch_i(br_branch_i), .br_btaken_i(br_btaken_i)
    ,.isd_v_i(isd_v_i), .isd_pc_i(isd_pc_i)
    ,.expected_npc_o(expected_npc_o), .npc_r_o(npc_r)
    ,.mismatch_o(mismatch), .poison_isd_o(poison_isd_o)
    ,.last_branch_o(last_branch), .last_btaken_o(last_btaken)
    );

  director_fsm i_director_fsm
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.freeze_i(freeze_i), .commit_wfi_i(commit_wfi_i)
    ,.cmd_enq_v_i(cmd_v), .cmd_enq_opcode_i(cmd_opcode)
    ,.queue_empty_n_i(empty_n)
    ,.suppress_iss_o(suppress_iss_o), .unfreeze_o(unfreeze_o), .is_wait_o(is_wait)
    );

  fe_cmd_encoder #(.vaddr_width_p(vaddr_width_p)) i_fe_cmd_encoder
    (.commit_unfreeze_i(commit_unfreeze_i), .commit_wfi_i(commit_wfi_i)
    ,.commit_fencei_i(commit_fencei_i), .commit_eret_i(commit_eret_i)
    ,.commit_exception_i(commit_exception_i), .commit_interrupt_i(commit_interrupt_i)
    ,.commit_npc_i(commit_npc_i), .commit_priv_i(commit_priv_i)
    ,.npc_r_i(npc_r), .expected_npc_i(expected_npc_o), .mismatch_i(mismatch)
    ,.last_branch_i(last_branch), .last_btaken_i(last_btaken)
    ,.isd_v_i(isd_v_i), .isd_metadata_i(isd_metadata_i)
    ,.is_wait_i(is_wait), .irq_waiting_i(irq_waiting_i), .queue_ready_i(queue_ready)
    ,.cmd_v_o(cmd_v), .cmd_opcode_o(cmd_opcode)
    ,.cmd_vaddr_o(cmd_vaddr), .cmd_operands_o(cmd_operands)
    );

  fe_cmd_queue #(.vaddr_width_p(vaddr_width_p), .queue_els_p(queue_els_p)) i_fe_cmd_queue
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.enq_v_i(cmd_v), .enq_opcode_i(cmd_opcode)
    ,.enq_vaddr_i(cmd_vaddr), .enq_operands_i(cmd_operands)
    ,.fe_cmd_yumi_i(fe_cmd_yumi_i), .ready_o(queue_ready)
    ,.fe_cmd_v_o(fe_cmd_v_o), .fe_cmd_opcode_o(fe_cmd_opcode_o)
    ,.fe_cmd_vaddr_o(fe_cmd_vaddr_o), .fe_cmd_operands_o(fe_cmd_operands_o)
    ,.empty_n_o(empty_n), .empty_r_o(cmd_empty_o), .full_r_o(cmd_full_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_be_director.sv
// Testbench for the back-end director
//   stimulus and expected value table applied in a loop
//   FIFO model of the front-end command queue
//   watchdog and closing report
`timescale 1ns/10ps
`default_nettype none

module tb_be_director;

  localparam int vw      = be_dir_pkg::default_vaddr_width;
  localparam int els     = be_dir_pkg::default_queue_els;
  localparam int period  = 8;

  typedef struct {
    logic [6:0]    ctl;    // npc_w, unfreeze, wfi, fencei, eret, exception, irq
    logic [vw-1:0] cnpc;
    logic [1:0]    priv;
    logic [2:0]    br;     // valid, branch, taken
    logic [vw-1:0] bnpc;
    logic          isd;
    logic [vw-1:0] ipc;
    logic [7:0]    meta;
    logic [1:0]    ymode;  // 0 low, 1 drain, 2 random
    logic [vw-1:0] enpc;
    logic [3:0]    exp;    // check suppress, poison, suppress, unfreeze
    logic          due;
    logic [2:0]    op;
    logic [vw-1:0] va;
    logic [15:0]   ops;
  } row_t;

  typedef struct {
    logic [2:0]    op;
    logic [vw-1:0] va;
    logic [15:0]   ops;
  } cmd_t;

  logic clk_i;
  logic reset_i;
  logic commit_npc_w_v_i, commit_unfreeze_i, commit_wfi_i, commit_fencei_i;
  logic commit_eret_i, commit_exception_i, commit_interrupt_i;
  logic [vw-1:0] commit_npc_i;
  logic [1:0]    commit_priv_i;
  logic          br_v_i, br_branch_i, br_btaken_i;
  logic [vw-1:0] br_npc_i;
  logic          isd_v_i;
  logic [vw-1:0] isd_pc_i;
  logic [7:0]    isd_metadata_i;
  logic          freeze_i, irq_waiting_i, fe_cmd_yumi_i;
  logic [vw-1:0] expected_npc_o, fe_cmd_vaddr_o;
  logic          poison_isd_o, suppress_iss_o, unfreeze_o, cmd_empty_o, cmd_full_o;
  logic [2:0]    fe_cmd_opcode_o;
  logic          fe_cmd_v_o;
  fe_cmd_pkg::fe_operands_u fe_cmd_operands_o;

  row_t   rows[$];
  cmd_t   model_q[$];
  int     row_errs;
  int     total_errs;
  int     failed_rows;
  integer seed;
  logic   table_ready;

  be_director #(.vaddr_width_p(vw), .queue_els_p(els)) i_dut
    (.clk_i, .reset_i, .commit_npc_w_v_i, .commit_npc_i, .commit_unfreeze_i
    ,.commit_wfi_i, .commit_fencei_i, .commit_eret_i, .commit_exception_i
    ,.commit_interrupt_i, .commit_priv_i, .br_v_i, .br_npc_i, .br_branch_i
    ,.br_btaken_i, .isd_v_i, .isd_pc_i, .isd_metadata_i, .freeze_i, .irq_waiting_i
    ,.expected_npc_o, .poison_isd_o, .suppress_iss_o, .unfreeze_o, .cmd_empty_o
    ,.cmd_full_o, .fe_cmd_opcode_o, .fe_cmd_vaddr_o, .fe_cmd_operands_o
    ,.fe_cmd_v_o, .fe_cmd_yumi_i
    );

  initial
  begin
    clk_i = 1'b0;
    forever #(period / 2) clk_i = ~clk_i;
  end

  // Operand words {pad, subop, priv, reason, metadata} and {pad, taken, metadata}
  function automatic logic [15:0] redir(input logic [1:0] subop, input logic [1:0] priv,
                                        input logic [1:0] reason, input logic [7:0] meta);
    redir = {2'b00, subop, priv, reason, meta};
  endfunction

  function automatic logic [15:0] atta(input logic taken, input logic [7:0] meta);
    atta = {7'b0, taken, meta};
  endfunction

  task automatic add_row(input logic [6:0] ctl, input logic [vw-1:0] cnpc,
                         input logic [1:0] priv, input logic [2:0] br,
                         input logic [vw-1:0] bnpc, input logic isd,
                         input logic [vw-1:0] ipc, input logic [7:0] meta,
                         input logic [1:0] ymode, input logic [vw-1:0] enpc,
                         input logic [3:0] exp, input logic due, input logic [2:0] op,
                         input logic [vw-1:0] va, input logic [15:0] ops);
    row_t r;
    r = '{ctl, cnpc, priv, br, bnpc, isd, ipc, meta, ymode, enpc, exp, due, op, va, ops};
    rows.push_back(r);
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR %s: got %0h expected %0h", name, got, exp);
      row_errs++;
    end
  endtask

  // Outputs while reset is held
  task automatic check_reset;
    check_field("unfreeze_o", unfreeze_o, 1'b0);
    check_field("suppress_iss_o", suppress_iss_o, 1'b1);
    check_field("fe_cmd_v_o", fe_cmd_v_o, 1'b0);
    check_field("cmd_empty_o", cmd_empty_o, 1'b1);
    check_field("cmd_full_o", cmd_full_o, 1'b0);
  endtask

  task automatic drive_row(input row_t r);
    int rnd;
    {commit_npc_w_v_i, commit_unfreeze_i, commit_wfi_i, commit_fencei_i,
     commit_eret_i, commit_exception_i, irq_waiting_i} = r.ctl;
    commit_npc_i = r.cnpc;
    commit_priv_i = r.priv;
    {br_v_i, br_branch_i, br_btaken_i} = r.br;
    br_npc_i = r.bnpc;
    isd_v_i = r.isd;
    isd_pc_i = r.ipc;
    isd_metadata_i = r.meta;
    rnd = $random(seed);
    // Front end only acknowledges a valid head
    if (model_q.size() == 0)
      fe_cmd_yumi_i = 1'b0;
    else if (r.ymode == 2'd2)
      fe_cmd_yumi_i = rnd[0];
    else
      fe_cmd_yumi_i = (r.ymode == 2'd1);
  endtask

  task automatic check_row(input row_t r);
    check_field("expected_npc_o", expected_npc_o, r.enpc);
    check_field("poison_isd_o", poison_isd_o, r.exp[2]);
    if (r.exp[3])
      check_field("suppress_iss_o", suppress_iss_o, r.exp[1]);
    check_field("unfreeze_o", unfreeze_o, r.exp[0]);
    check_field("fe_cmd_v_o", fe_cmd_v_o, model_q.size() != 0);
    check_field("cmd_empty_o", cmd_empty_o, model_q.size() == 0);
    check_field("cmd_full_o", cmd_full_o, model_q.size() == els);
    if (model_q.size() != 0)
    begin
      check_field("fe_cmd_opcode_o", fe_cmd_opcode_o, model_q[0].op);
      check_field("fe_cmd_vaddr_o", fe_cmd_vaddr_o, model_q[0].va);
      check_field("fe_cmd_operands_o", fe_cmd_operands_o, model_q[0].ops);
    end
  endtask

  // Queue contents after the coming edge
  task automatic update_model(input row_t r);
    logic full_before;
    full_before = (model_q.size() == els);
    if (fe_cmd_yumi_i)
      void'(model_q.pop_front());
    if (r.due && !full_before)
      model_q.push_back('{r.op, r.va, r.ops});
  endtask

  task automatic build_table;
    add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h0, 4'b1011, 0, 0, 0, 0);
    add_row(7'b1000000, 'h1000, 0, 3'b000, 0, 0, 0, 0, 1, 'h1000, 4'b1110, 0, 0, 0, 0);
    add_row(7'b0100000, 0, 3, 3'b000, 0, 0, 0, 0, 1, 'h1000, 4'b1010,
            1, fe_cmd_pkg::fe_op_state_reset, 'h1000, redir(0, 3, 0, 0));
    add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h1000, 4'b1010, 0, 0, 0, 0);
    add_row(7'b0000000, 0, 0, 3'b111, 'h2000, 0, 0, 0, 1, 'h2000, 4'b1000, 0, 0, 0, 0);
    add_row(7'b0000000, 0, 0, 3'b000, 0, 1, 'h2004, 'h5a, 1, 'h2000, 4'b1100,
            1, fe_cmd_pkg::fe_op_pc_redirect, 'h2000,
            redir(fe_cmd_pkg::fe_subop_branch_mispredict, 0,
                  fe_cmd_pkg::fe_reason_pred_taken_wrong, 'h5a));
    add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h2000, 4'b1010, 0, 0, 0, 0);
    add_row(7'b0000000, 0, 0, 3'b000, 0, 1, 'h3000, 'h11, 1, 'h2000, 4'b1100,
            1, fe_cmd_pkg::fe_op_pc_redirect, 'h2000,
            redir(fe_cmd_pkg::fe_subop_branch_mispredict, 0,
                  fe_cmd_pkg::fe_reason_not_a_branch, 'h11));
    add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h2000, 4'b1010, 0, 0, 0, 0);
    // Commit write beats the branch write
    add_row(7'b1000000, 'h4000, 0, 3'b110, 'h5000, 0, 0, 0, 1, 'h4000, 4'b1100, 0, 0, 0, 0);
    add_row(7'b0000000, 0, 0, 3'b000, 0, 1, 'h4000, 'h33, 1, 'h4000, 4'b1000,
            1, fe_cmd_pkg::fe_op_attaboy, 'h4000, atta(0, 'h33));
    add_row(7'b0000000, 0, 0, 3'b000, 0, 1, 'h4000, 0, 1, 'h4000, 4'b1000, 0, 0, 0, 0);
    add_row(7'b0000110, 'h8000, 1, 3'b000, 0, 0, 0, 0, 1, 'h4000, 4'b1000,
            1, fe_cmd_pkg::fe_op_pc_redirect, 'h8000, redir(fe_cmd_pkg::fe_subop_eret, 1, 0, 0));
    add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h4000, 4'b1010, 0, 0, 0, 0);
    add_row(7'b0010000, 'h4100, 0, 3'b000, 0, 0, 0, 0, 1, 'h4000, 4'b1000,
            1, fe_cmd_pkg::fe_op_wait, 'h4100, 16'h0);
    add_row(7'b0000001, 'h9000, 3, 3'b000, 0, 0, 0, 0, 1, 'h4000, 4'b1010,
            1, fe_cmd_pkg::fe_op_pc_redirect, 'h9000, redir(fe_cmd_pkg::fe_subop_trap, 3, 0, 0));
    add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h4000, 4'b1010, 0, 0, 0, 0);
    // Fill the queue with yumi low so the last two are dropped
    for (int k = 0; k < 6; k++)
      add_row(7'b0001000, 'ha000 + k, 0, 3'b000, 0, 0, 0, 0, 0, 'h4000,
              (k == 0) ? 4'b1000 : 4'b1010, 1, fe_cmd_pkg::fe_op_icache_fence,
              'ha000 + k, 16'h0);
    for (int k = 0; k < 6; k++)
      add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 2, 'h4000, 4'b0000, 0, 0, 0, 0);
    for (int k = 0; k < 4; k++)
      add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h4000, 4'b0000, 0, 0, 0, 0);
    add_row(7'b0000000, 0, 0, 3'b000, 0, 0, 0, 0, 1, 'h4000, 4'b1000, 0, 0, 0, 0);
  endtask

  initial
  begin
    wait (table_ready === 1'b1);
    #((rows.size() + 4) * period * 2);
    $display("Timeout: the run did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    table_ready = 1'b0;
    seed = 32'h867ae5d8;
    total_errs = 0;
    failed_rows = 0;
    reset_i = 1'b1;
    freeze_i = 1'b0;
    commit_interrupt_i = 1'b0;
    drive_row('{default: '0});
    build_table();
    table_ready = 1'b1;
    @(posedge clk_i);
    #1;
    row_errs = 0;
    check_reset();
    total_errs += row_errs;
    if (row_errs != 0)
      failed_rows++;
    $display("reset: %s", (row_errs == 0) ? "ok" : "failed");
    @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    foreach (rows[i])
    begin
      row_errs = 0;
      drive_row(rows[i]);
      #3;
      check_row(rows[i]);
      update_model(rows[i]);
      total_errs += row_errs;
      if (row_errs != 0)
        failed_rows++;
      $display("row %0d: %s", i, (row_errs == 0) ? "ok" : "failed");
      @(posedge clk_i);
      #1;
    end
    $display("%0d rows, %0d failed, %0d errors", rows.size(), failed_rows, total_errs);
    if (total_errs == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/fe_cmd_pkg.sv
design/be_dir_pkg.sv
design/npc_tracker.sv
design/director_fsm.sv
design/fe_cmd_encoder.sv
design/fe_cmd_queue.sv
design/be_director.sv
tb/tb_be_director.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_be_director
FILELIST := verilog.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(wildcard design/*.sv tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)
